//--- common/heapPkg.sv
/*
  Types shared by the heap blocks: width typedefs, the command and error
  encodings of the request port, and the controller states.
*/
`include "heap_macros.svh"

package heapPkg;

  // --------------------------------------------------------------------
  // Widths with a meaning
  // --------------------------------------------------------------------
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId;       // Number of an array
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndex;  // Position in an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize;     // 0 up to HEAP_LENGTH
  typedef logic [`HEAP_DATA_BITS-1:0]  dataWord;      // Element and result

  // --------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------
  typedef enum logic [3:0] {
    cmdClear,     // Empty the whole heap
    cmdAlloc,     // New array, freed ones first
    cmdFree,      // Return array for reuse
    cmdWrite,     // Store element, may grow size
    cmdRead,      // Element inside size
    cmdSize,      // Current size
    cmdPush,      // Append at the end
    cmdPop,       // Remove from the end
    cmdAdd,       // Add in place, new value back
    cmdSubtract   // Subtract in place, new value back
  } heapCommand;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,  // Array never allocated or already freed
    errOutOfBounds,   // Index not below size
    errFull,          // Push at full length
    errEmpty,         // Pop at size zero
    errOutOfMemory    // No array left to hand out
  } heapError;

  typedef enum logic [1:0] {stIdle, stCheck, stExecute, stAck} controlState;

endpackage

//--- common/heap_macros.svh
/*
  Global sizes of the array heap: number of arrays, array length and
  element width. Included by the package and by the modules that size logic.
*/
`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

// ----------------------------------------------------------------------
// Base widths
// ----------------------------------------------------------------------
// Bits in an array number
`define HEAP_ARRAY_BITS 3
// Bits in an element index
`define HEAP_INDEX_BITS 3
// Width of one element and of the result word
`define HEAP_DATA_BITS 16

// ----------------------------------------------------------------------
// Derived counts
// ----------------------------------------------------------------------
// Number of arrays in the heap
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)
// Elements per array
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)

`endif

//--- dv/heapMemoryTb.sv
/*
  Testbench of the array heap. Builds a table of commands with expected
  results and error codes, then runs each row through the req/ack port.
  Stops at the first mismatch or timeout.
*/
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapMemoryTb import heapPkg::*; ();

  logic        clock;
  logic        reset;
  logic        req;
  heapCommand  command;
  arrayId      array;
  elementIndex index;
  dataWord     data;
  logic        ack;
  dataWord     result;
  heapError    error;

  logic [31:0] lcgState;               // Random data source
  heapCommand  rowCommand   [$];       // Stimulus and expected values
  arrayId      rowArray     [$];
  elementIndex rowIndex     [$];
  dataWord     rowData      [$];
  dataWord     rowResult    [$];
  heapError    rowError     [$];

  heapMemory i_heapMemory (
    .clock, .reset, .req, .command, .array, .index, .data,
    .ack, .result, .error
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;         // 4 ns period
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic dataWord nextData();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];            // Upper bits are the better ones
  endfunction

  task automatic stopOnFailure();
    $display("Regression failed");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic addRow(input heapCommand cmd, input arrayId arr, input elementIndex idx,
                        input dataWord dat, input dataWord expResult, input heapError expError);
    rowCommand.push_back(cmd);
    rowArray.push_back(arr);
    rowIndex.push_back(idx);
    rowData.push_back(dat);
    rowResult.push_back(expResult);
    rowError.push_back(expError);
  endtask

  task automatic buildTable();
    dataWord pushData [`HEAP_LENGTH];
    dataWord writeWord;
    dataWord wordA;
    dataWord wordB;
    dataWord wordC;
    dataWord sum;
    dataWord diff;
    // Fresh arrays in order, then LIFO reuse
    addRow(cmdAlloc, 0, 0, 0, 16'd0, errNone);
    addRow(cmdAlloc, 0, 0, 0, 16'd1, errNone);
    addRow(cmdAlloc, 0, 0, 0, 16'd2, errNone);
    addRow(cmdFree, 1, 0, 0, 16'd0, errNone);
    addRow(cmdAlloc, 0, 0, 0, 16'd1, errNone);   // Freed array 1 back
    // Write past the end grows array 2 to size 3
    writeWord = nextData();
    addRow(cmdWrite, 2, 2, writeWord, writeWord, errNone);
    addRow(cmdSize, 2, 0, 0, 16'd3, errNone);
    addRow(cmdRead, 2, 2, 0, writeWord, errNone);
    addRow(cmdRead, 2, 3, 0, 16'd0, errOutOfBounds);
    // Push and pop on array 0
    addRow(cmdPop, 0, 0, 0, 16'd0, errEmpty);
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      pushData[i] = nextData();
      addRow(cmdPush, 0, 0, pushData[i], pushData[i], errNone);
    end
    addRow(cmdPush, 0, 0, nextData(), 16'd0, errFull);
    for (int i = `HEAP_LENGTH - 1; i >= 0; i--) begin
      addRow(cmdPop, 0, 0, 0, pushData[i], errNone);  // Reverse order
    end
    addRow(cmdPop, 0, 0, 0, 16'd0, errEmpty);
    // In-place add and subtract on array 1
    wordA = nextData();
    wordB = nextData();
    wordC = nextData();
    sum   = wordA + wordB;             // 16-bit wrap
    diff  = sum - wordC;
    addRow(cmdWrite, 1, 4, wordA, wordA, errNone);  // Size becomes 5
    addRow(cmdAdd, 1, 4, wordB, sum, errNone);
    addRow(cmdRead, 1, 4, 0, sum, errNone);
    addRow(cmdSubtract, 1, 4, wordC, diff, errNone);
    addRow(cmdRead, 1, 4, 0, diff, errNone);
    addRow(cmdWrite, 1, 0, 16'hfff0, 16'hfff0, errNone);
    addRow(cmdAdd, 1, 0, 16'h0025, 16'h0015, errNone);       // Wraps up
    addRow(cmdSubtract, 1, 0, 16'h0020, 16'hfff5, errNone);  // Wraps down
    addRow(cmdRead, 1, 0, 0, 16'hfff5, errNone);
    addRow(cmdAdd, 1, 5, 16'h0001, 16'd0, errOutOfBounds);
    // Double free and access after free
    addRow(cmdFree, 2, 0, 0, 16'd0, errNone);
    addRow(cmdFree, 2, 0, 0, 16'd0, errNotAllocated);
    addRow(cmdRead, 2, 2, 0, 16'd0, errNotAllocated);
    // Use up all arrays, stack first
    addRow(cmdAlloc, 0, 0, 0, 16'd2, errNone);
    for (int i = 3; i < `HEAP_ARRAYS; i++) begin
      addRow(cmdAlloc, 0, 0, 0, dataWord'(i), errNone);
    end
    addRow(cmdAlloc, 0, 0, 0, 16'd0, errOutOfMemory);
    // Clear empties everything
    addRow(cmdWrite, 0, 5, writeWord, writeWord, errNone);
    addRow(cmdSize, 0, 0, 0, 16'd6, errNone);
    addRow(cmdClear, 0, 0, 0, 16'd0, errNone);
    addRow(cmdRead, 1, 0, 0, 16'd0, errNotAllocated);
    addRow(cmdAlloc, 0, 0, 0, 16'd0, errNone);    // Counter restarts
    addRow(cmdSize, 0, 0, 0, 16'd0, errNone);
    addRow(cmdAlloc, 0, 0, 0, 16'd1, errNone);
  endtask

  // ----------------------------------------------------------------------
  // One four-phase transfer and its checks
  // ----------------------------------------------------------------------
  task automatic runRow(input int row);
    int waitCycles;
    @(posedge clock);
    req     <= 1'b1;
    command <= rowCommand[row];
    array   <= rowArray[row];
    index   <= rowIndex[row];
    data    <= rowData[row];
    waitCycles = 0;
    @(negedge clock);
    while (!ack) begin
      waitCycles++;
      if (waitCycles >= 20) begin
        $display("Timeout: ack did not rise for row %0d within 20 cycles", row);
        stopOnFailure();
      end
      @(negedge clock);
    end
    // Sampling edge plus three FSM cycles
    assert (waitCycles == 4) else begin
      $display("ERROR at %0t ns: row %0d ack after %0d cycles, expected 4",
               $time, row, waitCycles);
      stopOnFailure();
    end
    assert (result == rowResult[row]) else begin
      $display("ERROR at %0t ns: row %0d %s result %h, expected %h",
               $time, row, rowCommand[row].name(), result, rowResult[row]);
      stopOnFailure();
    end
    assert (error == rowError[row]) else begin
      $display("ERROR at %0t ns: row %0d %s error %s, expected %s",
               $time, row, rowCommand[row].name(), error.name(), rowError[row].name());
      stopOnFailure();
    end
    @(posedge clock);
    req <= 1'b0;
    waitCycles = 0;
    @(negedge clock);
    while (ack) begin
      waitCycles++;
      if (waitCycles >= 20) begin
        $display("Timeout: ack did not fall for row %0d within 20 cycles", row);
        stopOnFailure();
      end
      @(negedge clock);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    reset    = 1'b1;
    req      = 1'b0;
    command  = cmdClear;
    array    = '0;
    index    = '0;
    data     = '0;
    lcgState = 32'hbb00_d5d7;
    buildTable();
    repeat (2) @(posedge clock);       // Two reset cycles
    reset <= 1'b0;
    @(negedge clock);
    assert (!ack && error == errNone) else begin
      $display("ERROR at %0t ns: ack %b error %s after reset", $time, ack, error.name());
      stopOnFailure();
    end
    for (int row = 0; row < rowCommand.size(); row++) begin
      runRow(row);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+common
common/heapPkg.sv
heap/heapControl.sv
heap/heapAllocator.sv
heap/heapStore.sv
rtl/heapMemory.sv
dv/heapMemoryTb.sv

//--- heap/heapAllocator.sv
/*
  Hands out array numbers. Freed arrays are reused last-in first-out before
  fresh ones come from a counter; a flag per array tracks which are live.
*/
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapAllocator import heapPkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   allocRequest,   // One-cycle strobe
  input  logic   freeRequest,    // One-cycle strobe, array below
  input  logic   clearHeap,      // Forget every array
  input  arrayId array,          // Array presented by the controller
  output arrayId allocatedId,    // Next array to hand out
  output logic   allocOk,        // Low when nothing is left
  output logic   isAllocated     // Flag of the presented array
);

  arrayId                    freedStack [`HEAP_ARRAYS];  // Freed array numbers
  logic [`HEAP_ARRAY_BITS:0] stackDepth;                 // Entries in freedStack
  logic [`HEAP_ARRAY_BITS:0] freshCount;                 // Arrays never handed out start here
  logic [`HEAP_ARRAYS-1:0]   allocatedFlags;             // One per array
  logic                      stackEmpty;

  // --------------------------------------------------------------------
  // Next array and status
  // --------------------------------------------------------------------
  assign stackEmpty  = (stackDepth == '0);
  assign allocatedId = stackEmpty ? freshCount[`HEAP_ARRAY_BITS-1:0]  // Counter or top of stack
                                  : freedStack[stackDepth[`HEAP_ARRAY_BITS-1:0] - 1'b1];
  assign allocOk     = !stackEmpty || (freshCount < `HEAP_ARRAYS);
  assign isAllocated = allocatedFlags[array];

  // --------------------------------------------------------------------
  // Counter, stack pointer and flags
  // --------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || clearHeap) begin
      stackDepth     <= '0;
      freshCount     <= '0;
      allocatedFlags <= '0;
    end else if (allocRequest) begin
      if (stackEmpty) begin
        freshCount <= freshCount + 1'b1;       // Take a fresh array
      end else begin
        stackDepth <= stackDepth - 1'b1;       // Reuse last freed
      end
      allocatedFlags[allocatedId] <= 1'b1;
    end else if (freeRequest) begin
      stackDepth            <= stackDepth + 1'b1;
      allocatedFlags[array] <= 1'b0;           // Second free now fails
    end
  end

  // Stack storage, only written on a free
  always_ff @(posedge clock) begin
    if (freeRequest && !allocRequest) begin
      freedStack[stackDepth[`HEAP_ARRAY_BITS-1:0]] <= array;
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------
  stackBounded: assert property (@(posedge clock) disable iff (reset)
    stackDepth <= `HEAP_ARRAYS)
    else $error("freed-array stack overflow");

  // The controller must block frees of arrays that are not live
  freeOnlyLive: assert property (@(posedge clock) disable iff (reset)
    freeRequest |-> isAllocated)
    else $error("free of an array that is not allocated");

endmodule

//--- heap/heapControl.sv
/*
  Command FSM of the heap. Runs the four-phase req/ack handshake, checks
  each command against allocator and store state, then strobes one of them
  for a single cycle and returns the result word with an error code.
*/
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapControl import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req,           // Held high for the whole command
  input  heapCommand  command,       // Steady while req is high
  input  arrayId      array,
  input  elementIndex index,
  input  logic        allocOk,       // Allocator still has an array
  input  arrayId      allocatedId,   // Array the next alloc hands out
  input  logic        isAllocated,   // Flag of the presented array
  input  arraySize    currentSize,   // Size of the presented array
  input  dataWord     resultWord,    // Store result, valid in stAck
  output logic        ack,
  output heapError    error,
  output dataWord     result,
  output logic        allocRequest,  // One-cycle strobes
  output logic        freeRequest,
  output logic        clearHeap,
  output logic        storeEnable,
  output heapCommand  storeOp,
  output arrayId      initArray      // Array whose size resets on alloc
);

  controlState state;                // Handshake FSM
  heapError    checkError;           // Outcome of the checks
  logic        needsArray;           // Command works on an existing array
  logic        indexInside;          // Index below current size
  logic        execute;              // Error-free execute cycle

  // --------------------------------------------------------------------
  // Checks, sampled in stCheck
  // --------------------------------------------------------------------
  always_comb begin
    needsArray  = (command != cmdClear) && (command != cmdAlloc);
    indexInside = ({1'b0, index} < currentSize);
    checkError  = errNone;
    if (needsArray && !isAllocated) begin
      checkError = errNotAllocated;           // Also catches a double free
    end else begin
      case (command)
        cmdRead, cmdAdd, cmdSubtract: begin
          if (!indexInside) begin
            checkError = errOutOfBounds;
          end
        end
        cmdPush: begin
          if (currentSize == `HEAP_LENGTH) begin
            checkError = errFull;
          end
        end
        cmdPop: begin
          if (currentSize == '0) begin
            checkError = errEmpty;
          end
        end
        cmdAlloc: begin
          if (!allocOk) begin
            checkError = errOutOfMemory;
          end
        end
        default: begin
          checkError = errNone;              // Clear, free, write, size
        end
      endcase
    end
  end

  // --------------------------------------------------------------------
  // FSM and handshake
  // --------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= stIdle;
      ack   <= 1'b0;
      error <= errNone;
    end else begin
      case (state)
        stIdle: begin
          if (req) begin
            state <= stCheck;
          end
        end
        stCheck: begin
          error <= checkError;               // Held until the next command
          state <= stExecute;
        end
        stExecute: begin
          state <= stAck;                    // Store and allocator update here
        end
        stAck: begin
          if (req) begin
            ack <= 1'b1;                     // Stays high under back-pressure
          end else begin
            ack   <= 1'b0;
            state <= stIdle;
          end
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

  // Result captured with the rising ack, zero for a skipped command
  always_ff @(posedge clock) begin
    if (state == stAck && !ack) begin
      result <= (error == errNone) ? resultWord : '0;
    end
  end

  // --------------------------------------------------------------------
  // Strobes
  // --------------------------------------------------------------------
  assign execute      = (state == stExecute) && (error == errNone);
  assign allocRequest = execute && (command == cmdAlloc);
  assign freeRequest  = execute && (command == cmdFree);
  assign clearHeap    = execute && (command == cmdClear);
  assign storeEnable  = execute;             // Store answers every command
  assign storeOp      = command;
  assign initArray    = allocatedId;         // Still the old id before the edge

  ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> req)
    else $error("ack rose without req");

endmodule

//--- heap/heapStore.sv
/*
  Element memory and size table of the heap. Executes one data operation
  on the edge after storeEnable and registers its result word for the
  controller; size and element of the presented array are always visible.
*/
`timescale 1ns/1ps
`include "heap_macros.svh"

module heapStore import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        storeEnable,  // One-cycle strobe
  input  heapCommand  storeOp,      // Operation to run
  input  arrayId      array,
  input  elementIndex index,
  input  dataWord     data,
  input  arrayId      initArray,    // New array on alloc
  input  logic        clearHeap,    // Empty every array
  output arraySize    currentSize,  // Size of the presented array
  output dataWord     readWord,     // Element at the presented index
  output dataWord     resultWord    // Registered result
);

  dataWord     memory    [`HEAP_ARRAYS][`HEAP_LENGTH];  // Fixed block per array
  arraySize    sizeTable [`HEAP_ARRAYS];               // Live size per array
  elementIndex tailIndex;                              // First free slot
  elementIndex lastIndex;                              // Last live slot
  dataWord     sumWord;
  dataWord     diffWord;

  // --------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------
  assign currentSize = sizeTable[array];
  assign readWord    = memory[array][index];
  assign tailIndex   = currentSize[`HEAP_INDEX_BITS-1:0];  // Only used below full
  assign lastIndex   = tailIndex - 1'b1;                   // Only used above empty
  assign sumWord     = readWord + data;                    // Wraps to data width
  assign diffWord    = readWord - data;

  // --------------------------------------------------------------------
  // Size table
  // --------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || clearHeap) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizeTable[i] <= '0;
      end
    end else if (storeEnable) begin
      case (storeOp)
        cmdAlloc: begin
          sizeTable[initArray] <= '0;              // Fresh or reused, starts empty
        end
        cmdWrite: begin
          if ({1'b0, index} >= currentSize) begin
            sizeTable[array] <= {1'b0, index} + 1'b1;  // Grow to index+1
          end
        end
        cmdPush: begin
          sizeTable[array] <= currentSize + 1'b1;
        end
        cmdPop: begin
          sizeTable[array] <= currentSize - 1'b1;
        end
        default: ;                                 // Size unchanged
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Elements and result
  // --------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (storeEnable) begin
      case (storeOp)
        cmdWrite: begin
          memory[array][index] <= data;
          resultWord           <= data;
        end
        cmdRead:  resultWord <= readWord;
        cmdSize:  resultWord <= dataWord'(currentSize);
        cmdPush: begin
          memory[array][tailIndex] <= data;
          resultWord               <= data;
        end
        cmdPop:   resultWord <= memory[array][lastIndex];  // Old last element
        cmdAdd: begin
          memory[array][index] <= sumWord;
          resultWord           <= sumWord;
        end
        cmdSubtract: begin
          memory[array][index] <= diffWord;
          resultWord           <= diffWord;
        end
        cmdAlloc: resultWord <= dataWord'(initArray);    // Number handed out
        default:  resultWord <= '0;                       // Clear and free
      endcase
    end
  end

  sizeBounded: assert property (@(posedge clock) disable iff (reset)
    currentSize <= `HEAP_LENGTH)
    else $error("array size beyond array length");

endmodule

//--- rtl/heapMemory.sv
/*
  Top of the array heap. Wires the command FSM to the allocator and the
  element store behind a four-phase req/ack port.
*/
`timescale 1ns/1ps

module heapMemory import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        req,      // Four-phase request
  input  heapCommand  command,
  input  arrayId      array,
  input  elementIndex index,
  input  dataWord     data,
  output logic        ack,
  output dataWord     result,
  output heapError    error
);

  // Controller to allocator
  logic       allocRequest;
  logic       freeRequest;
  logic       clearHeap;
  logic       allocOk;
  logic       isAllocated;
  arrayId     allocatedId;
  // Controller to store
  logic       storeEnable;
  heapCommand storeOp;
  arrayId     initArray;
  arraySize   currentSize;
  dataWord    resultWord;

  heapControl i_heapControl (
    .clock, .reset, .req, .command, .array, .index,
    .allocOk, .allocatedId, .isAllocated, .currentSize, .resultWord,
    .ack, .error, .result,
    .allocRequest, .freeRequest, .clearHeap, .storeEnable, .storeOp, .initArray
  );

  heapAllocator i_heapAllocator (
    .clock, .reset, .allocRequest, .freeRequest, .clearHeap, .array,
    .allocatedId, .allocOk, .isAllocated
  );

  heapStore i_heapStore (
    .clock, .reset, .storeEnable, .storeOp, .array, .index, .data,
    .initArray, .clearHeap, .currentSize,
    .readWord   (),                      // Element only needed inside the store
    .resultWord
  );

endmodule
